/* design/fraise_pkg.sv */
// ==========================================================================
// sizes, register map, array and comparator codes, comparator config
// ==========================================================================
package fraise_pkg;

    localparam int unsigned data_width       = 32;
    localparam int unsigned lane_count       = 4;
    localparam int unsigned lane_log2        = 2;
    localparam int unsigned obs_width        = 3;
    localparam int unsigned array_addr_width = 5;  // lane bits + word bits
    localparam int unsigned result_width     = 8;
    localparam int unsigned settle_cycles    = 3;  // readout cycles ignored before sampling

    // register map
    localparam logic [data_width-1:0] reg_start        = 32'h10;
    localparam logic [data_width-1:0] on_off_addr      = reg_start + 32'h00;
    localparam logic [data_width-1:0] obs_addr         = reg_start + 32'h08;
    localparam logic [data_width-1:0] launch_addr      = reg_start + 32'h10;
    localparam logic [data_width-1:0] res_valid_addr   = reg_start + 32'h14;
    localparam logic [data_width-1:0] res_addr         = reg_start + 32'h18;
    localparam logic [data_width-1:0] irq_en_addr      = reg_start + 32'h20;
    localparam logic [data_width-1:0] precision_addr   = reg_start + 32'h24;
    localparam logic [data_width-1:0] comp_instr_addr  = reg_start + 32'h28;
    localparam logic [data_width-1:0] comp_ref_addr    = reg_start + 32'h2C;
    localparam logic [data_width-1:0] comp_result_addr = reg_start + 32'h30;
    localparam logic [data_width-1:0] comp_bypass_addr = reg_start + 32'h34;

    typedef enum logic [1:0] {
        instr_read_obs = 2'd0,
        instr_readout  = 2'd1
    } array_instr_e;

    // any other code gives a lane decision of 0
    typedef enum logic [7:0] {
        comp_eq  = 8'd0,
        comp_gt  = 8'd1,
        comp_lt  = 8'd2,
        comp_min = 8'd3,
        comp_max = 8'd4
    } comp_instr_e;

    typedef logic [lane_count-1:0][result_width-1:0] lane_vec_t;
    typedef logic [lane_count-1:0][obs_width-1:0]    obs_vec_t;

    typedef struct packed {
        lane_vec_t instr;
        lane_vec_t reference;
        lane_vec_t precision;  // only used by comp_eq
        logic      irq_en;
        logic      bypass;
    } comp_cfg_t;

endpackage

/* design/array_cmd_if.sv */
// ==========================================================================
// one array operation, sequencer to pulse generator
// ==========================================================================
interface array_cmd_if;

    logic                                    op_valid;
    logic                                    op_ready;  // generator idle
    fraise_pkg::array_instr_e                instr;
    logic [fraise_pkg::array_addr_width-1:0] col;
    logic [fraise_pkg::array_addr_width-1:0] row;

    modport seq (output op_valid, instr, col, row, input op_ready);
    modport gen (input op_valid, instr, col, row, output op_ready);

endinterface

/* design/host_regs.sv */
// ==========================================================================
// host request/response handshake, register file and result valid flag
// ==========================================================================
module host_regs (
    input  logic                                clk_i,
    input  logic                                counter_read_reset,
    input  logic                                req_valid_i,
    output logic                                ready_o,
    input  logic                                req_host_addr_i,
    input  logic [fraise_pkg::data_width-1:0]   req_addr_i,
    input  logic                                req_wen_i,
    input  logic [fraise_pkg::data_width-1:0]   req_wdata_i,
    input  logic [fraise_pkg::data_width/8-1:0] req_ben_i,
    output logic                                resp_valid_o,
    input  logic                                resp_ready_i,
    output logic [fraise_pkg::data_width-1:0]   resp_data_o,
    output logic                                resp_ini_addr_o,
    input  logic                                busy_i,
    input  logic                                done_i,
    input  fraise_pkg::lane_vec_t               results_i,
    input  logic [fraise_pkg::lane_count-1:0]   decision_i,
    output logic                                start_o,
    output fraise_pkg::obs_vec_t                obs_o,
    output fraise_pkg::comp_cfg_t               cfg_o,
    output logic                                res_valid_o
);

    logic                              on_off_q;  // continuous mode
    logic                              launch_q;
    logic [fraise_pkg::data_width-1:0] obs_q;
    fraise_pkg::lane_vec_t             res_q;
    fraise_pkg::comp_cfg_t             cfg_q;
    logic [fraise_pkg::data_width-1:0] ben_mask;
    logic [fraise_pkg::data_width-1:0] rd_data;
    logic                              accept;

    assign ready_o = !resp_valid_o && !busy_i;
    assign accept  = req_valid_i && ready_o;
    assign start_o = (launch_q || on_off_q) && !busy_i;
    assign cfg_o   = cfg_q;

    always_comb begin
        for (int i = 0; i < fraise_pkg::data_width / 8; i++) begin
            ben_mask[8*i +: 8] = {8{req_ben_i[i]}};
        end
        // lane i observation in the low bits of byte i
        for (int i = 0; i < fraise_pkg::lane_count; i++) begin
            obs_o[i] = obs_q[8*i +: fraise_pkg::obs_width];
        end
    end

    always_comb begin
        case (req_addr_i)
            fraise_pkg::on_off_addr:      rd_data = {31'b0, on_off_q};
            fraise_pkg::obs_addr:         rd_data = obs_q;
            fraise_pkg::launch_addr:      rd_data = {31'b0, launch_q};
            fraise_pkg::res_valid_addr:   rd_data = {31'b0, res_valid_o};
            fraise_pkg::res_addr:         rd_data = res_q;
            fraise_pkg::irq_en_addr:      rd_data = {31'b0, cfg_q.irq_en};
            fraise_pkg::precision_addr:   rd_data = cfg_q.precision;
            fraise_pkg::comp_instr_addr:  rd_data = cfg_q.instr;
            fraise_pkg::comp_ref_addr:    rd_data = cfg_q.reference;
            fraise_pkg::comp_result_addr: rd_data = {28'b0, decision_i};
            fraise_pkg::comp_bypass_addr: rd_data = {31'b0, cfg_q.bypass};
            default:                      rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            on_off_q        <= 1'b0;
            launch_q        <= 1'b0;
            obs_q           <= '0;
            res_q           <= '0;
            cfg_q           <= '0;
            res_valid_o     <= 1'b0;
            resp_valid_o    <= 1'b0;
            resp_data_o     <= '0;
            resp_ini_addr_o <= 1'b0;
        end else begin
            if (start_o) begin
                launch_q <= 1'b0;  // sequencer has it
            end
            if (accept) begin
                resp_valid_o    <= 1'b1;
                resp_data_o     <= rd_data;  // old value on a write
                resp_ini_addr_o <= req_host_addr_i;
                if (!req_wen_i && req_addr_i == fraise_pkg::res_addr) begin
                    res_valid_o <= 1'b0;
                end
                if (req_wen_i) begin
                    case (req_addr_i)
                        fraise_pkg::on_off_addr:      on_off_q <= req_wdata_i[0];
                        fraise_pkg::obs_addr:
                            obs_q <= (obs_q & ~ben_mask) | (req_wdata_i & ben_mask);
                        fraise_pkg::launch_addr:      launch_q <= req_wdata_i[0];
                        fraise_pkg::irq_en_addr:      cfg_q.irq_en <= req_wdata_i[0];
                        fraise_pkg::precision_addr:   cfg_q.precision <= req_wdata_i;
                        fraise_pkg::comp_instr_addr:  cfg_q.instr <= req_wdata_i;
                        fraise_pkg::comp_ref_addr:    cfg_q.reference <= req_wdata_i;
                        fraise_pkg::comp_bypass_addr: cfg_q.bypass <= req_wdata_i[0];
                        default: ;
                    endcase
                end
            end else if (resp_ready_i) begin
                resp_valid_o <= 1'b0;
            end
            if (done_i) begin
                res_q       <= results_i;  // kept while the next inference runs
                res_valid_o <= 1'b1;
            end
        end
    end

    // a waiting response holds still until the host takes it
    resp_hold_a: assert property (@(posedge clk_i) disable iff (counter_read_reset)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_data_o)
            && $stable(resp_ini_addr_o));

endmodule

/* design/inference_seq.sv */
// ==========================================================================
// inference FSM, lane and readout counters, result shift registers
// ==========================================================================
module inference_seq (
    input  logic                              clk_i,
    input  logic                              counter_read_reset,
    input  logic                              start_i,
    input  fraise_pkg::obs_vec_t              obs_i,
    input  logic [fraise_pkg::lane_count-1:0] array_bit_i,
    output logic                              busy_o,
    output logic                              done_o,
    output fraise_pkg::lane_vec_t             results_o,
    array_cmd_if.seq                          cmd
);

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_readout,
        st_done
    } seq_state_e;

    seq_state_e                       state_q;
    logic [fraise_pkg::lane_log2-1:0] lane_q;
    logic [3:0]                       cnt_q;  // readout ops issued
    logic                             readout_end;
    logic                             xfer;

    assign busy_o      = state_q != st_idle;
    assign done_o      = state_q == st_done;
    assign xfer        = cmd.op_valid && cmd.op_ready;
    assign readout_end = cnt_q == 4'(fraise_pkg::settle_cycles + fraise_pkg::result_width);

    // one read per lane, then one readout op per readout cycle
    assign cmd.op_valid = state_q == st_read || (state_q == st_readout && !readout_end);
    assign cmd.instr    = (state_q == st_readout) ? fraise_pkg::instr_readout
                                                  : fraise_pkg::instr_read_obs;
    assign cmd.col      = {lane_q, obs_i[lane_q]};
    assign cmd.row      = '0;

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            state_q   <= st_idle;
            lane_q    <= '0;
            cnt_q     <= '0;
            results_o <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (start_i) begin
                        state_q   <= st_read;
                        lane_q    <= '0;
                        cnt_q     <= '0;
                        results_o <= '0;
                    end
                end
                st_read: begin
                    if (xfer) begin
                        lane_q <= lane_q + 1'b1;
                        if (lane_q == '1) begin
                            state_q <= st_readout;
                        end
                    end
                end
                st_readout: begin
                    if (xfer || readout_end) begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                    // edge ending readout cycle cnt_q-1, msb first
                    if (cnt_q > 4'(fraise_pkg::settle_cycles)) begin
                        for (int i = 0; i < fraise_pkg::lane_count; i++) begin
                            results_o[i] <= {results_o[i][fraise_pkg::result_width-2:0],
                                             array_bit_i[i]};
                        end
                    end
                    if (readout_end) begin
                        state_q <= st_done;
                    end
                end
                default: state_q <= st_idle;  // st_done
            endcase
        end
    end

    // an idle sequencer leaves no operation running in the generator
    no_idle_op_a: assert property (@(posedge clk_i) disable iff (counter_read_reset)
        !busy_o |-> cmd.op_ready);

endmodule

/* design/array_pulse_gen.sv */
// ==========================================================================
// array read-pulse FSM and registered array pins
// ==========================================================================
module array_pulse_gen (
    input  logic                                    clk_i,
    input  logic                                    counter_read_reset,
    array_cmd_if.gen                                cmd,
    output fraise_pkg::array_instr_e                array_instr_o,
    output logic [fraise_pkg::array_addr_width-1:0] array_col_o,
    output logic [fraise_pkg::array_addr_width-1:0] array_row_o,
    output logic                                    array_csl_o,
    output logic                                    array_cwl_o
);

    typedef enum logic [2:0] {
        pg_idle,
        pg_rise,     // csl and cwl high
        pg_sl_fall,
        pg_wl_high,
        pg_wl_fall
    } pulse_state_e;

    pulse_state_e state_q;

    assign cmd.op_ready = state_q == pg_idle;

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            state_q       <= pg_idle;
            array_instr_o <= fraise_pkg::instr_read_obs;
            array_col_o   <= '0;
            array_row_o   <= '0;
            array_csl_o   <= 1'b0;
            array_cwl_o   <= 1'b0;
        end else begin
            case (state_q)
                pg_idle: begin
                    if (cmd.op_valid) begin
                        array_instr_o <= cmd.instr;
                        array_col_o   <= cmd.col;
                        array_row_o   <= cmd.row;
                        if (cmd.instr == fraise_pkg::instr_read_obs) begin
                            array_csl_o <= 1'b1;
                            array_cwl_o <= 1'b1;
                            state_q     <= pg_rise;
                        end
                    end else begin
                        array_instr_o <= fraise_pkg::instr_read_obs;  // rest code
                    end
                end
                pg_rise: begin
                    array_csl_o <= 1'b0;
                    state_q     <= pg_sl_fall;
                end
                pg_sl_fall: begin
                    array_cwl_o <= 1'b1;
                    state_q     <= pg_wl_high;
                end
                pg_wl_high: begin
                    array_cwl_o <= 1'b0;
                    state_q     <= pg_wl_fall;
                end
                default: state_q <= pg_idle;
            endcase
        end
    end

    // column select only inside a word line pulse, and for one cycle
    csl_in_cwl_a: assert property (@(posedge clk_i) disable iff (counter_read_reset)
        array_csl_o |-> array_cwl_o ##1 !array_csl_o);

endmodule

/* design/decision_unit.sv */
// ==========================================================================
// per-lane comparators, min/max search, decision register and interrupt
// ==========================================================================
module decision_unit (
    input  logic                              clk_i,
    input  logic                              counter_read_reset,
    input  logic                              done_i,
    input  logic                              res_valid_i,
    input  fraise_pkg::lane_vec_t             results_i,
    input  fraise_pkg::comp_cfg_t             cfg_i,
    output logic [fraise_pkg::lane_count-1:0] decision_o,
    output logic                              irq_o
);

    logic [fraise_pkg::lane_count-1:0] cmp_bits;
    logic [fraise_pkg::lane_count-1:0] min_bits;
    logic [fraise_pkg::lane_count-1:0] max_bits;
    logic [fraise_pkg::lane_count-1:0] next_decision;

    always_comb begin
        logic [fraise_pkg::result_width-1:0] diff;
        for (int i = 0; i < fraise_pkg::lane_count; i++) begin
            diff = (results_i[i] > cfg_i.reference[i]) ? results_i[i] - cfg_i.reference[i]
                                                       : cfg_i.reference[i] - results_i[i];
            case (fraise_pkg::comp_instr_e'(cfg_i.instr[i]))
                fraise_pkg::comp_eq: cmp_bits[i] = diff <= cfg_i.precision[i];
                fraise_pkg::comp_gt: cmp_bits[i] = results_i[i] > cfg_i.reference[i];
                fraise_pkg::comp_lt: cmp_bits[i] = results_i[i] < cfg_i.reference[i];
                default:             cmp_bits[i] = 1'b0;
            endcase
        end
    end

    // strict extremes, so a tie flags no lane
    always_comb begin
        min_bits = '1;
        max_bits = '1;
        for (int i = 0; i < fraise_pkg::lane_count; i++) begin
            for (int j = 0; j < fraise_pkg::lane_count; j++) begin
                if (i != j && results_i[i] >= results_i[j]) begin
                    min_bits[i] = 1'b0;
                end
                if (i != j && results_i[i] <= results_i[j]) begin
                    max_bits[i] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        case (fraise_pkg::comp_instr_e'(cfg_i.instr[0]))  // lane 0 code picks min/max
            fraise_pkg::comp_min: next_decision = min_bits;
            fraise_pkg::comp_max: next_decision = max_bits;
            default:              next_decision = cmp_bits;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            decision_o <= '0;
            irq_o      <= 1'b0;
        end else begin
            if (done_i) begin
                decision_o <= next_decision;
            end
            irq_o <= res_valid_i && cfg_i.irq_en && (cfg_i.bypass || decision_o != '0);
        end
    end

endmodule

/* design/fraise_top.sv */
// ==========================================================================
// accelerator top level, register file, sequencer, pulse generator, decision
// ==========================================================================
module fraise_top (
    input  logic                                    clk_i,
    input  logic                                    counter_read_reset,
    input  logic                                    req_valid_i,
    output logic                                    ready_o,
    input  logic                                    req_host_addr_i,
    input  logic [fraise_pkg::data_width-1:0]       req_addr_i,
    input  logic                                    req_wen_i,
    input  logic [fraise_pkg::data_width-1:0]       req_wdata_i,
    input  logic [fraise_pkg::data_width/8-1:0]     req_ben_i,
    output logic                                    resp_valid_o,
    input  logic                                    resp_ready_i,
    output logic [fraise_pkg::data_width-1:0]       resp_data_o,
    output logic                                    resp_ini_addr_o,
    output logic                                    irq_o,
    output logic [1:0]                              array_instr_o,
    output logic [fraise_pkg::array_addr_width-1:0] array_col_o,
    output logic [fraise_pkg::array_addr_width-1:0] array_row_o,
    output logic                                    array_csl_o,
    output logic                                    array_cwl_o,
    input  logic [fraise_pkg::lane_count-1:0]       array_bit_i
);

    logic                              start;
    logic                              busy;
    logic                              done;
    logic                              res_valid;
    fraise_pkg::obs_vec_t              obs;
    fraise_pkg::comp_cfg_t             cfg;
    fraise_pkg::lane_vec_t             results;
    logic [fraise_pkg::lane_count-1:0] decision;

    array_cmd_if cmd ();

    host_regs host_regs_inst (
        .*,
        .busy_i      (busy),
        .done_i      (done),
        .results_i   (results),
        .decision_i  (decision),
        .start_o     (start),
        .obs_o       (obs),
        .cfg_o       (cfg),
        .res_valid_o (res_valid)
    );

    inference_seq inference_seq_inst (
        .*,
        .start_i   (start),
        .obs_i     (obs),
        .busy_o    (busy),
        .done_o    (done),
        .results_o (results)
    );

    array_pulse_gen array_pulse_gen_inst (.*);

    decision_unit decision_unit_inst (
        .*,
        .done_i      (done),
        .res_valid_i (res_valid),
        .results_i   (results),
        .cfg_i       (cfg),
        .decision_o  (decision)
    );

endmodule

/* test/fraise_tb.sv */
// ==========================================================================
// testbench with clock, reset, array model, watchdog, bus tasks, directed tests
// ==========================================================================
module fraise_tb;

    logic        clk_i = 1'b0;
    logic        counter_read_reset = 1'b1;
    logic        req_valid_i = 1'b0;
    logic        req_host_addr_i = 1'b0;
    logic [31:0] req_addr_i = '0;
    logic        req_wen_i = 1'b0;
    logic [31:0] req_wdata_i = '0;
    logic [3:0]  req_ben_i = '0;
    logic        resp_ready_i = 1'b1;
    logic [3:0]  array_bit_i = '0;
    logic        ready_o, resp_valid_o, resp_ini_addr_o, irq_o, array_csl_o, array_cwl_o;
    logic [31:0] resp_data_o;
    logic [1:0]  array_instr_o;
    logic [4:0]  array_col_o, array_row_o;

    logic [31:0] rng_state = 32'hcbe9_ebe8;
    logic [7:0]  byte_tab [32];
    logic [4:0]  col_lat [4];
    int          rd_cycle = 0;
    int          cwl_run = 0;
    int          errors = 0;
    string       test_name = "";

    fraise_top fraise_top_inst (.*);

    always #20 clk_i = ~clk_i;

    // lane bytes, indexed by {lane, word}
    initial begin
        byte_tab = '{8'h3c, 8'h91, 8'h07, 8'hd2, 8'h5a, 8'he4, 8'h18, 8'ha7,
                     8'h3c, 8'h62, 8'hf0, 8'h2b, 8'hc8, 8'h75, 8'h0e, 8'h99,
                     8'hb3, 8'h4d, 8'h07, 8'hee, 8'h21, 8'h86, 8'h5f, 8'hca,
                     8'h70, 8'h1a, 8'hf0, 8'h9c, 8'h43, 8'hd7, 8'h2e, 8'hb5};
    end

    function automatic logic [7:0] lane_byte(input int lane, input logic [4:0] col);
        return byte_tab[{lane[1:0], col[2:0]}];
    endfunction

    // expected RES word for an observation vector
    function automatic logic [31:0] expect_results(input logic [31:0] obs);
        logic [31:0] r;
        for (int l = 0; l < 4; l++) begin
            r[8*l +: 8] = lane_byte(l, {l[1:0], obs[8*l +: 3]});
        end
        return r;
    endfunction

    function automatic logic [31:0] xorshift();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            errors++;
            $display("Error: %s %s expected %h actual %h", test_name, name, exp, act);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // array model, serial readout msb first from cycle 3
    always @(posedge clk_i) begin
        logic [7:0] b;
        #2;
        if (array_csl_o) begin
            col_lat[array_col_o[4:3]] = array_col_o;
            check_eq("read row", 0, array_row_o);
        end
        // word line up for three cycles of each read pulse
        if (array_cwl_o) begin
            cwl_run++;
        end else if (cwl_run != 0) begin
            check_eq("word line length", 3, cwl_run);
            cwl_run = 0;
        end
        if (array_instr_o == 2'd1) begin
            for (int l = 0; l < 4; l++) begin
                b = lane_byte(l, col_lat[l]);
                array_bit_i[l] = (rd_cycle >= 3 && rd_cycle <= 10) ? b[10-rd_cycle] : 1'b0;
            end
            rd_cycle++;
        end else begin
            rd_cycle = 0;
            array_bit_i = '0;
        end
    end

    initial begin
        repeat (20000) @(posedge clk_i);
        $display("watchdog expired before the tests finished");
        $display("Checks failed");
        $fatal(1);
    end

    task automatic bus_xfer(input logic wen, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] ben, output logic [31:0] rdata);
        req_valid_i     = 1'b1;
        req_wen_i       = wen;
        req_addr_i      = addr;
        req_wdata_i     = wdata;
        req_ben_i       = ben;
        req_host_addr_i = ~req_host_addr_i;
        while (!ready_o) @(posedge clk_i) #2;
        @(posedge clk_i) #2;
        req_valid_i = 1'b0;
        while (!resp_valid_o) @(posedge clk_i) #2;
        check_eq("resp_ini_addr", req_host_addr_i, resp_ini_addr_o);
        rdata = resp_data_o;
        if (resp_ready_i) begin
            @(posedge clk_i) #2;
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] old;
        bus_xfer(1'b1, addr, data, 4'hf, old);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        bus_xfer(1'b0, addr, '0, 4'h0, data);
    endtask

    task automatic wait_result();
        logic [31:0] v = 0;
        int n = 0;
        while (v[0] !== 1'b1) begin
            bus_read(32'h24, v);
            n++;
            if (n > 200) begin
                $display("inference never set the result valid flag");
                $display("Checks failed");
                $fatal(1);
            end
        end
    endtask

    // lane rules for the comparator and min/max search
    function automatic logic [3:0] expect_decision(input logic [31:0] res, input logic [31:0] ins,
                                                   input logic [31:0] rf, input logic [31:0] pr);
        logic [3:0] d;
        int r, c, diff;
        d = '0;
        for (int i = 0; i < 4; i++) begin
            r = res[8*i +: 8];
            c = rf[8*i +: 8];
            diff = (r > c) ? r - c : c - r;
            case (ins[8*i +: 8])
                8'd0: d[i] = diff <= pr[8*i +: 8];
                8'd1: d[i] = r > c;
                8'd2: d[i] = r < c;
                default: d[i] = 1'b0;
            endcase
        end
        if (ins[7:0] == 8'd3 || ins[7:0] == 8'd4) begin
            d = '1;
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    if (i != j && ins[7:0] == 8'd3 && res[8*i +: 8] >= res[8*j +: 8]) d[i] = 1'b0;
                    if (i != j && ins[7:0] == 8'd4 && res[8*i +: 8] <= res[8*j +: 8]) d[i] = 1'b0;
                end
            end
        end
        return d;
    endfunction

    task automatic run_inference(input logic [31:0] obs, output logic [31:0] res);
        bus_write(32'h18, obs);
        bus_write(32'h20, 32'h1);
        wait_result();
        bus_read(32'h28, res);
    endtask

    task automatic test_regs();
        logic [31:0] v;
        check_eq("reset ready", 1, ready_o);
        bus_read(32'h34, v);
        check_eq("reset precision", 0, v);
        bus_read(32'h20, v);
        check_eq("reset launch", 0, v);
        bus_write(32'h3c, 32'h1234_5678);
        bus_read(32'h3c, v);
        check_eq("reference readback", 32'h1234_5678, v);
        bus_read(32'h4c, v);
        check_eq("unknown address", 0, v);
        resp_ready_i = 1'b0;  // response back-pressure
        bus_read(32'h3c, v);
        repeat (3) @(posedge clk_i) #2;
        check_eq("held resp_valid", 1, resp_valid_o);
        check_eq("held ready", 0, ready_o);
        check_eq("held data", 32'h1234_5678, resp_data_o);
        resp_ready_i = 1'b1;
        @(posedge clk_i) #2;
        check_eq("released resp_valid", 0, resp_valid_o);
    endtask

    task automatic test_readout(input logic [31:0] obs, output logic [31:0] res);
        logic [31:0] v;
        run_inference(obs, res);
        for (int l = 0; l < 4; l++) begin
            check_eq("lane result", lane_byte(l, {l[1:0], obs[8*l +: 3]}), res[8*l +: 8]);
        end
        bus_read(32'h24, v);
        check_eq("valid cleared", 0, v);
    endtask

    task automatic test_compare(input logic [31:0] obs, input logic [31:0] ins,
                                input logic [31:0] rf, input logic [31:0] pr);
        logic [31:0] res, v;
        bus_write(32'h38, ins);
        bus_write(32'h3c, rf);
        bus_write(32'h34, pr);
        test_readout(obs, res);
        bus_read(32'h40, v);
        check_eq("comp_result", {28'b0, expect_decision(expect_results(obs), ins, rf, pr)}, v);
    endtask

    task automatic test_irq();
        logic [31:0] res;
        bus_write(32'h30, 32'h1);
        test_compare(32'h0, {4{8'd1}}, 32'h0, 32'h0);
        bus_write(32'h20, 32'h1);
        wait_result();  // valid stays set for the irq checks
        check_eq("irq with decision", 1, irq_o);
        bus_write(32'h30, 32'h0);
        @(posedge clk_i) #2;
        check_eq("irq disabled", 0, irq_o);
        bus_write(32'h38, {4{8'hff}});
        bus_write(32'h44, 32'h1);
        bus_write(32'h30, 32'h1);
        bus_write(32'h20, 32'h1);
        wait_result();
        check_eq("irq bypass", 1, irq_o);
        bus_write(32'h10, 32'h1);  // continuous mode
        bus_read(32'h28, res);
        wait_result();
        bus_write(32'h10, 32'h0);
    endtask

    initial begin
        logic [31:0] obs, res;
        repeat (5) @(posedge clk_i);
        #2 counter_read_reset = 1'b0;
        test_name = "registers";
        test_regs();
        test_name = "readout";
        obs = xorshift() & 32'h0707_0707;
        test_readout(obs, res);
        test_name = "compare";
        for (int c = 0; c < 3; c++) begin
            test_compare(obs, {4{c[7:0]}}, xorshift(), xorshift() & 32'h3f3f_3f3f);
        end
        test_name = "min max";
        test_compare(32'h0000_0000, {4{8'd3}}, 0, 0);  // tied minimum
        test_compare(32'h0000_0000, {4{8'd4}}, 0, 0);
        test_compare(32'h0101_0101, {4{8'd3}}, 0, 0);
        test_compare(32'h0101_0101, {4{8'd4}}, 0, 0);
        test_compare(32'h0202_0202, {4{8'd4}}, 0, 0);
        test_name = "interrupt";
        test_irq();
        if (errors == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule

/* build.f */
design/fraise_pkg.sv
design/array_cmd_if.sv
design/host_regs.sv
design/inference_seq.sv
design/array_pulse_gen.sv
design/decision_unit.sv
design/fraise_top.sv
test/fraise_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wall
TOP       ?= fraise_tb
RTL_TOP   ?= fraise_top
FILELIST  ?= build.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	-./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
